// File: hw/axi_fifo_rd_settings.svh
// Bus widths and FIFO depth macros for the AXI4 read FIFO
`ifndef AXI_FIFO_RD_SETTINGS_SVH
`define AXI_FIFO_RD_SETTINGS_SVH

// R data bus width in bits
`define DATA_WIDTH 32

// AR address width in bits
`define ADDR_WIDTH 32

// Transaction ID width in bits
`define ID_WIDTH 4

// Beats held by the read data FIFO, power of two only
`define FIFO_DEPTH 16

// Index width into the FIFO memory
`define FIFO_ADDR_WIDTH ($clog2(`FIFO_DEPTH))

`endif

// File: hw/axi_fifo_rd_pkg.sv
// Vector typedefs and admission state enum for the AXI4 read FIFO
`include "axi_fifo_rd_settings.svh"

package axi_fifo_rd_pkg;

    // Credit counter must hold a full 256-beat burst
    localparam int CREDIT_WIDTH = (`FIFO_ADDR_WIDTH + 1 > 9) ? `FIFO_ADDR_WIDTH + 1 : 9;

    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`ID_WIDTH-1:0]   id_t;

    // AXI burst length minus one
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [1:0] resp_t;

    // Top bit is the wrap flag
    typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

    typedef logic [CREDIT_WIDTH-1:0] credit_t;

    typedef enum logic {
        IDLE,
        WAIT
    } adm_state_e;

endpackage

// File: hw/r_beat_if.sv
// R beat interface with producer and consumer modports
interface r_beat_if;
    import axi_fifo_rd_pkg::*;

    data_t data;
    id_t   id;
    resp_t resp;
    logic  last;
    logic  valid;
    logic  ready;

    // FIFO read side
    modport producer (
        output data, id, resp, last, valid,
        input  ready
    );

    // Output register side
    modport consumer (
        input  data, id, resp, last, valid,
        output ready
    );

endinterface

// File: hw/ar_admission.sv
// AR admission stage that holds a burst until the data FIFO can take it
`include "axi_fifo_rd_settings.svh"

module ar_admission (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_fifo_rd_pkg::id_t    s_arid,
    input  axi_fifo_rd_pkg::addr_t  s_araddr,
    input  axi_fifo_rd_pkg::len_t   s_arlen,
    input  axi_fifo_rd_pkg::size_t  s_arsize,
    input  axi_fifo_rd_pkg::burst_t s_arburst,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output axi_fifo_rd_pkg::id_t    m_arid,
    output axi_fifo_rd_pkg::addr_t  m_araddr,
    output axi_fifo_rd_pkg::len_t   m_arlen,
    output axi_fifo_rd_pkg::size_t  m_arsize,
    output axi_fifo_rd_pkg::burst_t m_arburst,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  logic                    beat_done
);
    import axi_fifo_rd_pkg::*;

    // One spare bit so credit plus len never wraps in the compare
    localparam int SUM_WIDTH = CREDIT_WIDTH + 1;

    adm_state_e           state;
    adm_state_e           state_next;
    credit_t              credit;
    credit_t              credit_next;
    len_t                 len_sel;
    logic [SUM_WIDTH-1:0] need;
    logic                 fits;
    logic                 admit;
    logic                 arvalid_next;
    logic                 arready_next;

    // New request in IDLE, held request in WAIT
    assign len_sel = (state == IDLE) ? s_arlen : m_arlen;

    assign need = SUM_WIDTH'(credit) + SUM_WIDTH'(len_sel) + SUM_WIDTH'(1);

    // Empty pipeline admits any burst so oversized ones cannot deadlock
    assign fits = (credit == '0) || (need <= SUM_WIDTH'(`FIFO_DEPTH));

    always_comb begin
        state_next   = state;
        admit        = 1'b0;
        arvalid_next = m_arvalid && !m_arready;
        case (state)
            IDLE: begin
                if (s_arvalid && s_arready) begin
                    if (fits) begin
                        admit = 1'b1;
                    end else begin
                        state_next = WAIT;
                    end
                end
            end
            WAIT: begin
                if (fits) begin
                    admit      = 1'b1;
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
        if (admit) begin
            arvalid_next = 1'b1;
        end
    end

    // Accept a new request only with nothing held
    assign arready_next = (state_next == IDLE) && !arvalid_next;

    always_comb begin
        credit_next = credit;
        if (admit) begin
            credit_next = credit_next + credit_t'(len_sel) + credit_t'(1);
        end
        if (beat_done) begin
            credit_next = credit_next - credit_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            credit    <= '0;
            m_arvalid <= 1'b0;
            s_arready <= 1'b0;
        end else begin
            state     <= state_next;
            credit    <= credit_next;
            m_arvalid <= arvalid_next;
            s_arready <= arready_next;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) begin
            m_arid    <= s_arid;
            m_araddr  <= s_araddr;
            m_arlen   <= s_arlen;
            m_arsize  <= s_arsize;
            m_arburst <= s_arburst;
        end
    end

endmodule

// File: hw/r_beat_fifo.sv
// R beat FIFO with registered addresses and a prefetch register on the read side
`include "axi_fifo_rd_settings.svh"

module r_beat_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_fifo_rd_pkg::data_t rdata,
    input  axi_fifo_rd_pkg::id_t   rid,
    input  axi_fifo_rd_pkg::resp_t rresp,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    r_beat_if.producer             out
);
    import axi_fifo_rd_pkg::*;

    // Beat layout is {resp, id, last, data}
    localparam int LAST_BIT   = `DATA_WIDTH;
    localparam int ID_LSB     = LAST_BIT + 1;
    localparam int RESP_LSB   = ID_LSB + `ID_WIDTH;
    localparam int BEAT_WIDTH = RESP_LSB + 2;

    logic [BEAT_WIDTH-1:0]       mem [`FIFO_DEPTH];
    logic [BEAT_WIDTH-1:0]       beat_in;
    logic [BEAT_WIDTH-1:0]       pf_data;
    logic                        pf_valid;
    fifo_ptr_t                   wr_ptr;
    fifo_ptr_t                   wr_ptr_next;
    fifo_ptr_t                   rd_ptr;
    fifo_ptr_t                   rd_ptr_next;
    logic [`FIFO_ADDR_WIDTH-1:0] wr_addr;
    logic [`FIFO_ADDR_WIDTH-1:0] rd_addr;
    logic                        full;
    logic                        empty;
    logic                        write;
    logic                        read;

    assign beat_in = {rresp, rid, rlast, rdata};

    // Same index with opposite wrap bits
    assign full  = (wr_ptr[`FIFO_ADDR_WIDTH] != rd_ptr[`FIFO_ADDR_WIDTH]) &&
                   (wr_ptr[`FIFO_ADDR_WIDTH-1:0] == rd_ptr[`FIFO_ADDR_WIDTH-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign rready = !full;
    assign write  = rvalid && !full;

    // Refill prefetch when it is empty or handing its beat over
    assign read = !empty && (out.ready || !pf_valid);

    assign wr_ptr_next = write ? wr_ptr + fifo_ptr_t'(1) : wr_ptr;
    assign rd_ptr_next = read ? rd_ptr + fifo_ptr_t'(1) : rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            wr_addr  <= '0;
            rd_addr  <= '0;
            pf_valid <= 1'b0;
        end else begin
            wr_ptr  <= wr_ptr_next;
            rd_ptr  <= rd_ptr_next;
            wr_addr <= wr_ptr_next[`FIFO_ADDR_WIDTH-1:0];
            rd_addr <= rd_ptr_next[`FIFO_ADDR_WIDTH-1:0];
            if (out.ready || !pf_valid) begin
                pf_valid <= !empty;
            end
        end
    end

    // Storage and prefetch data
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_addr] <= beat_in;
        end
        if (read) begin
            pf_data <= mem[rd_addr];
        end
    end

    assign out.valid = pf_valid;
    assign out.data  = pf_data[`DATA_WIDTH-1:0];
    assign out.last  = pf_data[LAST_BIT];
    assign out.id    = pf_data[ID_LSB +: `ID_WIDTH];
    assign out.resp  = pf_data[RESP_LSB +: 2];

endmodule

// File: hw/r_output_reg.sv
// Output register driving the master-side R channel and flagging consumed beats
module r_output_reg (
    input  logic                   clk,
    input  logic                   rst,
    r_beat_if.consumer             in,
    output axi_fifo_rd_pkg::data_t rdata,
    output axi_fifo_rd_pkg::id_t   rid,
    output axi_fifo_rd_pkg::resp_t rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready,
    output logic                   beat_done
);
    logic load;

    // Take a new beat when empty or when the master accepts the current one
    assign load     = rready || !rvalid;
    assign in.ready = load;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (load) begin
            rvalid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rdata <= in.data;
            rid   <= in.id;
            rresp <= in.resp;
            rlast <= in.last;
        end
    end

    // Returns one credit to admission
    assign beat_done = rvalid && rready;

endmodule

// File: hw/axi_fifo_rd.sv
// AXI4 read channel buffer with burst admission and R beat FIFO
module axi_fifo_rd (
    input  logic                    clk,
    input  logic                    rst,

    // Toward the AXI master
    input  axi_fifo_rd_pkg::id_t    s_axi_arid,
    input  axi_fifo_rd_pkg::addr_t  s_axi_araddr,
    input  axi_fifo_rd_pkg::len_t   s_axi_arlen,
    input  axi_fifo_rd_pkg::size_t  s_axi_arsize,
    input  axi_fifo_rd_pkg::burst_t s_axi_arburst,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output axi_fifo_rd_pkg::id_t    s_axi_rid,
    output axi_fifo_rd_pkg::data_t  s_axi_rdata,
    output axi_fifo_rd_pkg::resp_t  s_axi_rresp,
    output logic                    s_axi_rlast,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,

    // Toward the AXI slave
    output axi_fifo_rd_pkg::id_t    m_axi_arid,
    output axi_fifo_rd_pkg::addr_t  m_axi_araddr,
    output axi_fifo_rd_pkg::len_t   m_axi_arlen,
    output axi_fifo_rd_pkg::size_t  m_axi_arsize,
    output axi_fifo_rd_pkg::burst_t m_axi_arburst,
    output logic                    m_axi_arvalid,
    input  logic                    m_axi_arready,
    input  axi_fifo_rd_pkg::id_t    m_axi_rid,
    input  axi_fifo_rd_pkg::data_t  m_axi_rdata,
    input  axi_fifo_rd_pkg::resp_t  m_axi_rresp,
    input  logic                    m_axi_rlast,
    input  logic                    m_axi_rvalid,
    output logic                    m_axi_rready
);
    logic beat_done;

    r_beat_if r_beat ();

    ar_admission u_admission (
        .clk       (clk),
        .rst       (rst),
        .s_arid    (s_axi_arid),
        .s_araddr  (s_axi_araddr),
        .s_arlen   (s_axi_arlen),
        .s_arsize  (s_axi_arsize),
        .s_arburst (s_axi_arburst),
        .s_arvalid (s_axi_arvalid),
        .s_arready (s_axi_arready),
        .m_arid    (m_axi_arid),
        .m_araddr  (m_axi_araddr),
        .m_arlen   (m_axi_arlen),
        .m_arsize  (m_axi_arsize),
        .m_arburst (m_axi_arburst),
        .m_arvalid (m_axi_arvalid),
        .m_arready (m_axi_arready),
        .beat_done (beat_done)
    );

    r_beat_fifo u_fifo (
        .clk    (clk),
        .rst    (rst),
        .rdata  (m_axi_rdata),
        .rid    (m_axi_rid),
        .rresp  (m_axi_rresp),
        .rlast  (m_axi_rlast),
        .rvalid (m_axi_rvalid),
        .rready (m_axi_rready),
        .out    (r_beat.producer)
    );

    r_output_reg u_output (
        .clk       (clk),
        .rst       (rst),
        .in        (r_beat.consumer),
        .rdata     (s_axi_rdata),
        .rid       (s_axi_rid),
        .rresp     (s_axi_rresp),
        .rlast     (s_axi_rlast),
        .rvalid    (s_axi_rvalid),
        .rready    (s_axi_rready),
        .beat_done (beat_done)
    );

endmodule

// File: testbench/axi_fifo_rd_assertions.sv
// Bound handshake stability and FIFO occupancy assertions
`include "axi_fifo_rd_settings.svh"

module axi_fifo_rd_assertions #(
    parameter int PAYLOAD_WIDTH   = 8,
    parameter bit CHECK_OCCUPANCY = 1'b1
) (
    input logic                             clk,
    input logic                             rst,
    input axi_fifo_rd_pkg::fifo_ptr_t       wr_ptr,
    input axi_fifo_rd_pkg::fifo_ptr_t       rd_ptr,
    input logic                             hs_valid,
    input logic                             hs_ready,
    input logic [PAYLOAD_WIDTH-1:0]         hs_payload
);
    import axi_fifo_rd_pkg::*;

    // Occupancy from the wrap-bit pointers
    if (CHECK_OCCUPANCY) begin : g_occupancy
        assert property (@(posedge clk) disable iff (rst)
            fifo_ptr_t'(wr_ptr - rd_ptr) <= fifo_ptr_t'(`FIFO_DEPTH))
            else $error("FIFO pointer difference exceeds depth");
    end

    assert property (@(posedge clk) disable iff (rst)
        hs_valid && !hs_ready |=> hs_valid)
        else $error("Valid dropped before ready");

    assert property (@(posedge clk) disable iff (rst)
        hs_valid && !hs_ready |=> $stable(hs_payload))
        else $error("Payload changed while waiting for ready");

endmodule

bind r_beat_fifo axi_fifo_rd_assertions #(
    .PAYLOAD_WIDTH (`DATA_WIDTH + `ID_WIDTH + 3)
) u_fifo_checks (
    .clk        (clk),
    .rst        (rst),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .hs_valid   (out.valid),
    .hs_ready   (out.ready),
    .hs_payload ({out.resp, out.id, out.last, out.data})
);

// AR handshake checks only
bind ar_admission axi_fifo_rd_assertions #(
    .PAYLOAD_WIDTH   (`ID_WIDTH + `ADDR_WIDTH + 13),
    .CHECK_OCCUPANCY (1'b0)
) u_ar_checks (
    .clk        (clk),
    .rst        (rst),
    .wr_ptr     ('0),
    .rd_ptr     ('0),
    .hs_valid   (m_arvalid),
    .hs_ready   (m_arready),
    .hs_payload ({m_arid, m_araddr, m_arlen, m_arsize, m_arburst})
);

// File: testbench/axi_fifo_rd_tb.sv
// Testbench with AR master driver, slave memory model, R checker and result report
`include "axi_fifo_rd_settings.svh"

module axi_fifo_rd_tb;
    import axi_fifo_rd_pkg::*;

    localparam int MAX_CASES = 64;

    // Four-byte INCR bursts
    localparam size_t  AR_SIZE  = 3'd2;
    localparam burst_t AR_BURST = 2'b01;

    logic clk, rst;
    id_t s_axi_arid, s_axi_rid, m_axi_arid, m_axi_rid;
    addr_t s_axi_araddr, m_axi_araddr;
    len_t s_axi_arlen, m_axi_arlen;
    size_t s_axi_arsize, m_axi_arsize;
    burst_t s_axi_arburst, m_axi_arburst;
    data_t s_axi_rdata, m_axi_rdata;
    resp_t s_axi_rresp, m_axi_rresp;
    logic s_axi_arvalid, s_axi_arready, s_axi_rlast, s_axi_rvalid, s_axi_rready;
    logic m_axi_arvalid, m_axi_arready, m_axi_rlast, m_axi_rvalid, m_axi_rready;

    // Cases from the data file
    id_t  c_id [MAX_CASES];
    addr_t c_addr [MAX_CASES];
    len_t c_len [MAX_CASES];
    int   c_mode [MAX_CASES];
    int   n_cases = 0;

    // Slave request queue
    addr_t q_addr [$];
    len_t  q_len [$];
    id_t   q_id [$];

    integer seed;
    int errors = 0, burst_errors = 0, bursts_ok = 0;
    int ar_idx = 0, fwd_idx = 0, cur_burst = 0, beat_idx = 0, s_beat = 0;
    int outstanding = 0, limit = `FIFO_DEPTH, stall_left = 0;
    // Beats taken from the slave and not yet accepted by the master
    int buffered = 0;
    int cycles = 0, cycle_limit = 0;
    logic running = 0, finished = 0, timed_out = 0, stall_started = 0;
    logic bp_seen = 0, long_stall = 0;

    axi_fifo_rd UUT (.*);

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            burst_errors++;
        end
    endtask

    task automatic load_cases(output logic ok);
        integer fd, n;
        string line;
        logic [31:0] f_id, f_addr, f_len, f_mode;
        fd = $fopen("testbench/axi_fifo_rd_cases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h", f_id, f_addr, f_len, f_mode);
                    if (n == 4) begin
                        c_id[n_cases] = id_t'(f_id);
                        c_addr[n_cases] = f_addr;
                        c_len[n_cases] = len_t'(f_len);
                        c_mode[n_cases] = int'(f_mode);
                        cycle_limit += (int'(f_len) + 1) * 8;
                        if (f_mode == 2 && int'(f_len) + 1 > `FIFO_DEPTH + 2) long_stall = 1;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Timeout watchdog
    always @(posedge clk) begin
        cycles++;
        if (running && !finished && cycles >= cycle_limit) timed_out = 1;
    end

    always @(posedge clk) begin
        if (running && !finished) begin
            // Master AR side
            if (s_axi_arvalid && s_axi_arready) ar_idx++;
            // Slave AR acceptance
            if (m_axi_arvalid && m_axi_arready) begin
                q_addr.push_back(m_axi_araddr);
                q_len.push_back(m_axi_arlen);
                q_id.push_back(m_axi_arid);
                if (fwd_idx >= n_cases) begin
                    $display("AR forwarded at time %0t with no request left to send", $time);
                    errors++;
                end else begin
                    compare("m_axi_arid", 64'(m_axi_arid), 64'(c_id[fwd_idx]));
                    compare("m_axi_araddr", 64'(m_axi_araddr), 64'(c_addr[fwd_idx]));
                    compare("m_axi_arlen", 64'(m_axi_arlen), 64'(c_len[fwd_idx]));
                    compare("m_axi_arsize", 64'(m_axi_arsize), 64'(AR_SIZE));
                    compare("m_axi_arburst", 64'(m_axi_arburst), 64'(AR_BURST));
                end
                fwd_idx++;
                // Only a lone oversized burst may go past the FIFO depth
                if (outstanding == 0 && int'(m_axi_arlen) + 1 > `FIFO_DEPTH)
                    limit = int'(m_axi_arlen) + 1;
                else
                    limit = `FIFO_DEPTH;
                outstanding += int'(m_axi_arlen) + 1;
            end
            // Slave R side
            if (m_axi_rvalid && m_axi_rready) begin
                buffered++;
                s_beat++;
                if (s_beat > int'(q_len[0])) begin
                    void'(q_addr.pop_front());
                    void'(q_len.pop_front());
                    void'(q_id.pop_front());
                    s_beat = 0;
                end
            end
            if (stall_left > 0) begin
                stall_left--;
                if (!m_axi_rready) begin
                    // Memory full behind the prefetch and output registers
                    compare("buffered beats", 64'(buffered), 64'(`FIFO_DEPTH + 2));
                    bp_seen = 1;
                end
            end
            // Master R side
            if (s_axi_rvalid && !stall_started && cur_burst < n_cases &&
                c_mode[cur_burst] == 2) begin
                stall_started = 1;
                stall_left = 40;
            end
            if (s_axi_rvalid && s_axi_rready) begin
                outstanding--;
                buffered--;
                if (cur_burst >= n_cases) begin
                    $display("Beat received at time %0t with no burst expected", $time);
                    errors++;
                end else begin
                    compare("s_axi_rdata", 64'(s_axi_rdata),
                            64'(c_addr[cur_burst] + addr_t'(4 * beat_idx)));
                    compare("s_axi_rid", 64'(s_axi_rid), 64'(c_id[cur_burst]));
                    compare("s_axi_rresp", 64'(s_axi_rresp), 64'(0));
                    compare("s_axi_rlast", 64'(s_axi_rlast),
                            64'(beat_idx == int'(c_len[cur_burst])));
                    beat_idx++;
                    if (beat_idx > int'(c_len[cur_burst])) begin
                        $display("Burst %0d id %h len %0d: %s", cur_burst, c_id[cur_burst],
                                 c_len[cur_burst], (burst_errors == 0) ? "ok" : "errors");
                        if (burst_errors == 0) bursts_ok++;
                        burst_errors = 0;
                        beat_idx = 0;
                        stall_started = 0;
                        cur_burst++;
                        if (cur_burst == n_cases) finished = 1;
                    end
                end
            end
            if (outstanding > limit) begin
                $display("Outstanding beats %0d exceed limit %0d at time %0t",
                         outstanding, limit, $time);
                errors++;
            end

            #1;
            s_axi_arvalid = (ar_idx < n_cases);
            if (ar_idx < n_cases) begin
                s_axi_arid = c_id[ar_idx];
                s_axi_araddr = c_addr[ar_idx];
                s_axi_arlen = c_len[ar_idx];
            end
            m_axi_arready = $random(seed) % 4 == 0;
            // Raise rvalid with random gaps, hold it until accepted
            if (q_len.size() > 0 && (m_axi_rvalid || $random(seed) % 3 != 0)) begin
                m_axi_rvalid = 1;
                m_axi_rdata = q_addr[0] + addr_t'(4 * s_beat);
                m_axi_rid = q_id[0];
                m_axi_rresp = 2'b00;
                m_axi_rlast = (s_beat == int'(q_len[0]));
            end else begin
                m_axi_rvalid = 0;
            end
            if (cur_burst < n_cases && c_mode[cur_burst] == 1)
                s_axi_rready = $random(seed) % 2 == 0;
            else if (cur_burst < n_cases && c_mode[cur_burst] == 2)
                s_axi_rready = stall_started && stall_left == 0;
            else
                s_axi_rready = 1;
        end
    end

    initial begin
        logic ok;
        seed = 45401;
        rst = 1;
        s_axi_arid = '0;
        s_axi_araddr = '0;
        s_axi_arlen = '0;
        s_axi_arsize = AR_SIZE;
        s_axi_arburst = AR_BURST;
        s_axi_arvalid = 0;
        s_axi_rready = 1;
        m_axi_arready = 0;
        m_axi_rid = '0;
        m_axi_rdata = '0;
        m_axi_rresp = '0;
        m_axi_rlast = 0;
        m_axi_rvalid = 0;
        load_cases(ok);
        if (!ok || n_cases == 0) begin
            $display("Could not read any case from the cases file");
            errors++;
        end else begin
            cycle_limit += 200 + 10;
            repeat (10) @(posedge clk);
            #1;
            rst = 0;
            compare("s_axi_arready", 64'(s_axi_arready), 64'(0));
            compare("m_axi_arvalid", 64'(m_axi_arvalid), 64'(0));
            compare("s_axi_rvalid", 64'(s_axi_rvalid), 64'(0));
            burst_errors = 0;
            running = 1;
            wait (finished || timed_out);
            if (timed_out) begin
                $display("Timeout after %0d cycles with %0d bursts done", cycles, cur_burst);
                errors++;
            end
            if (long_stall && !bp_seen) begin
                $display("FIFO never back-pressured the slave during the long stall");
                errors++;
            end
        end
        $display("Bursts: %0d ok of %0d, errors: %0d", bursts_ok, n_cases, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: testbench/axi_fifo_rd_cases.txt
# Columns in hex: id address len stall_mode
# Stall mode 0 = always ready, 1 = random ready, 2 = 40-cycle stall
1 00001000 03 0
2 00002000 07 0
3 00003000 00 0
4 00004000 0f 0
5 00005000 1f 0
6 00006000 05 1
7 00007000 0b 1
8 00008000 02 1
9 00009000 1f 1
a 0000a000 07 2
b 0000b000 1f 2
c 0000c000 03 0
d 0000d000 09 1

// File: filelist.f
+incdir+hw
hw/axi_fifo_rd_pkg.sv
hw/r_beat_if.sv
hw/ar_admission.sv
hw/r_beat_fifo.sv
hw/r_output_reg.sv
hw/axi_fifo_rd.sv
testbench/axi_fifo_rd_assertions.sv
testbench/axi_fifo_rd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= axi_fifo_rd_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
